// File: rtl/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

	// ########################################
	// basic widths
	// ########################################

	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_idx_t;

	localparam int unsigned NUM_STAGES = 4;   // d, e, m, w.

	localparam instr_t   INSTR_NOP = 32'h0000_0000;
	localparam reg_idx_t REG_ZERO  = 5'd0;
	localparam reg_idx_t REG_LINK  = 5'd31;   // jal target.

	// ########################################
	// decode results
	// ########################################

	typedef enum logic [3:0] {
		KIND_NOP, KIND_ADDU, KIND_SUBU, KIND_ORI, KIND_LUI, KIND_LW,
		KIND_SW, KIND_BEQ, KIND_J, KIND_JAL, KIND_JR, KIND_UNKNOWN
	} instr_kind_e;

	typedef enum logic [2:0] {
		CLS_NONE, CLS_CAL_R, CLS_CAL_I, CLS_LOAD,
		CLS_STORE, CLS_BRANCH, CLS_JUMP_I, CLS_JUMP_R
	} instr_class_e;

	typedef enum logic [1:0] {ST_D, ST_E, ST_M, ST_W} stage_e;

	typedef struct packed {
		instr_kind_e  kind;
		instr_class_e cls;
		reg_idx_t     reg1;   // first source, zero if unused.
		reg_idx_t     reg2;   // second source, zero if unused.
		reg_idx_t     regw;   // destination, zero if none.
	} instr_info_t;

	// ########################################
	// control words
	// ########################################

	typedef enum logic [1:0] {NPC_SEQ, NPC_EQUAL, NPC_JUMP, NPC_REG} npc_mode_e;

	// pad moves the immediate into the upper half.
	typedef enum logic [1:0] {EXT_SIGNED, EXT_UNSIGNED, EXT_PAD} ext_mode_e;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_OR} alu_op_e;

	typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC8} wb_src_e;

	typedef struct packed {
		npc_mode_e npc_mode;
		ext_mode_e ext_mode;
		reg_idx_t  rf_raddr1;
		reg_idx_t  rf_raddr2;
	} ctrl_d_t;

	typedef struct packed {
		logic    alu_src;   // 1 picks the extended immediate.
		alu_op_e alu_op;
	} ctrl_e_t;

	typedef struct packed {
		logic dm_we;
	} ctrl_m_t;

	typedef struct packed {
		logic     rf_we;
		reg_idx_t rf_waddr;
		wb_src_e  wb_src;
	} ctrl_w_t;

	// ########################################
	// forwarding
	// ########################################

	typedef enum logic [3:0] {
		FWD_ORIG, FWD_E2D_PC8, FWD_M2D_ALU, FWD_M2D_PC8, FWD_W2D_RF,
		FWD_M2E_ALU, FWD_M2E_PC8, FWD_W2E_RF, FWD_W2M_RF
	} fwd_sel_e;

	typedef struct packed {
		fwd_sel_e d1;
		fwd_sel_e d2;
		fwd_sel_e e1;
		fwd_sel_e e2;
		fwd_sel_e m;
	} fwd_t;

endpackage

`default_nettype wire

// File: rtl/instr_decoder.sv
`default_nettype none

module instr_decoder (
	input  pipe_ctrl_pkg::instr_t      instr,
	output pipe_ctrl_pkg::instr_info_t info
);
	import pipe_ctrl_pkg::*;

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_ORI     = 6'h0D;
	localparam logic [5:0] OP_LUI     = 6'h0F;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2B;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUBU    = 6'h23;

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  shamt;
	reg_idx_t    rs;
	reg_idx_t    rt;
	reg_idx_t    rd;
	logic        is_special;
	instr_kind_e kind;

	assign opcode     = instr[31:26];
	assign rs         = instr[25:21];
	assign rt         = instr[20:16];
	assign rd         = instr[15:11];
	assign shamt      = instr[10:6];
	assign funct      = instr[5:0];
	assign is_special = (opcode == OP_SPECIAL);

	// any field mismatch falls through to unknown.
	always_comb begin
		if (instr == INSTR_NOP)
			kind = KIND_NOP;
		else if (is_special && funct == FN_ADDU && shamt == 5'd0)
			kind = KIND_ADDU;
		else if (is_special && funct == FN_SUBU && shamt == 5'd0)
			kind = KIND_SUBU;
		else if (opcode == OP_LUI && rs == REG_ZERO)
			kind = KIND_LUI;
		else if (opcode == OP_ORI)
			kind = KIND_ORI;
		else if (opcode == OP_LW)
			kind = KIND_LW;
		else if (opcode == OP_SW)
			kind = KIND_SW;
		else if (opcode == OP_BEQ)
			kind = KIND_BEQ;
		else if (opcode == OP_J)
			kind = KIND_J;
		else if (opcode == OP_JAL)
			kind = KIND_JAL;
		else if (is_special && funct == FN_JR && rt == REG_ZERO && rd == REG_ZERO)
			kind = KIND_JR;
		else
			kind = KIND_UNKNOWN;
	end

	always_comb begin
		info.kind = kind;
		info.cls  = CLS_NONE;
		info.reg1 = REG_ZERO;
		info.reg2 = REG_ZERO;
		info.regw = REG_ZERO;
		case (kind)
			KIND_ADDU, KIND_SUBU: begin
				info.cls  = CLS_CAL_R;
				info.reg1 = rs;
				info.reg2 = rt;
				info.regw = rd;
			end
			KIND_ORI, KIND_LUI: begin
				info.cls  = CLS_CAL_I;
				info.reg1 = (kind == KIND_ORI) ? rs : REG_ZERO;   // lui reads nothing.
				info.regw = rt;
			end
			KIND_LW: begin
				info.cls  = CLS_LOAD;
				info.reg1 = rs;
				info.regw = rt;
			end
			KIND_SW, KIND_BEQ: begin
				info.cls  = (kind == KIND_SW) ? CLS_STORE : CLS_BRANCH;
				info.reg1 = rs;
				info.reg2 = rt;
			end
			KIND_J, KIND_JAL: begin
				info.cls  = CLS_JUMP_I;
				info.regw = (kind == KIND_JAL) ? REG_LINK : REG_ZERO;
			end
			KIND_JR: begin
				info.cls  = CLS_JUMP_R;
				info.reg1 = rs;
			end
			default: ;   // nop and unknown stay empty.
		endcase

		// nothing downstream may see a register from an unclassified word.
		assert (info.cls != CLS_NONE ||
			(info.reg1 == REG_ZERO && info.reg2 == REG_ZERO && info.regw == REG_ZERO))
			else $error("decoder: class none with register fields set, instr %h", instr);
	end

endmodule

`default_nettype wire

// File: rtl/stage_tracker.sv
`default_nettype none

module stage_tracker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  pipe_ctrl_pkg::instr_t d_instr,
	output pipe_ctrl_pkg::instr_t stage_instr [pipe_ctrl_pkg::NUM_STAGES]
);
	import pipe_ctrl_pkg::*;

	instr_t e_instr;
	instr_t m_instr;
	instr_t w_instr;

	// ########################################
	// e, m, w stage registers
	// ########################################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_instr <= INSTR_NOP;
			m_instr <= INSTR_NOP;
			w_instr <= INSTR_NOP;
		end else begin
			e_instr <= stall ? INSTR_NOP : d_instr;   // bubble while d is held.
			m_instr <= e_instr;
			w_instr <= m_instr;
		end
	end

	assign stage_instr[ST_D] = d_instr;   // decode word comes straight in.
	assign stage_instr[ST_E] = e_instr;
	assign stage_instr[ST_M] = m_instr;
	assign stage_instr[ST_W] = w_instr;

	// a stalled decode word must never leak into execute.
	a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> stage_instr[ST_E] == INSTR_NOP)
		else $error("tracker: execute not bubbled after stall, got %h", e_instr);

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input  pipe_ctrl_pkg::instr_info_t stage_info [pipe_ctrl_pkg::NUM_STAGES],
	output logic                       stall,
	output logic                       pc_enable,
	output logic                       d_enable,
	output pipe_ctrl_pkg::fwd_t        fwd
);
	import pipe_ctrl_pkg::*;

	typedef logic [1:0] tick_t;

	localparam tick_t T_NEVER = 2'd3;   // later than any producer.

	instr_info_t d_info;
	instr_info_t e_info;
	instr_info_t m_info;
	instr_info_t w_info;

	assign d_info = stage_info[ST_D];
	assign e_info = stage_info[ST_E];
	assign m_info = stage_info[ST_M];
	assign w_info = stage_info[ST_W];

	function automatic logic fwable(input reg_idx_t src, input reg_idx_t dst);
		return (src == dst) && (src != REG_ZERO);
	endfunction

	// ########################################
	// use and new times
	// ########################################

	function automatic tick_t use_time1(input instr_class_e cls);
		case (cls)
			CLS_CAL_R, CLS_CAL_I, CLS_LOAD, CLS_STORE: return 2'd1;
			CLS_BRANCH, CLS_JUMP_R:                    return 2'd0;
			default:                                   return T_NEVER;
		endcase
	endfunction

	function automatic tick_t use_time2(input instr_class_e cls);
		case (cls)
			CLS_STORE:  return 2'd2;   // store data is needed in m.
			CLS_CAL_R:  return 2'd1;
			CLS_BRANCH: return 2'd0;
			default:    return T_NEVER;
		endcase
	endfunction

	function automatic tick_t new_time_e(input instr_class_e cls);
		case (cls)
			CLS_LOAD:             return 2'd2;
			CLS_CAL_R, CLS_CAL_I: return 2'd1;
			default:              return 2'd0;
		endcase
	endfunction

	// ########################################
	// forwarding priority
	// ########################################

	function automatic fwd_sel_e sel_to_d(input reg_idx_t src, input instr_info_t e,
		input instr_info_t m, input instr_info_t w);
		if (fwable(src, e.regw) && e.kind == KIND_JAL)
			return FWD_E2D_PC8;
		if (fwable(src, m.regw) && m.kind == KIND_JAL)
			return FWD_M2D_PC8;
		if (fwable(src, m.regw) && (m.cls == CLS_CAL_R || m.cls == CLS_CAL_I))
			return FWD_M2D_ALU;
		if (fwable(src, w.regw))
			return FWD_W2D_RF;
		return FWD_ORIG;
	endfunction

	function automatic fwd_sel_e sel_to_e(input reg_idx_t src, input instr_info_t m,
		input instr_info_t w);
		if (fwable(src, m.regw) && m.kind == KIND_JAL)
			return FWD_M2E_PC8;
		if (fwable(src, m.regw) && (m.cls == CLS_CAL_R || m.cls == CLS_CAL_I))
			return FWD_M2E_ALU;
		if (fwable(src, w.regw))
			return FWD_W2E_RF;
		return FWD_ORIG;
	endfunction

	always_comb begin
		tick_t t_use1;
		tick_t t_use2;
		tick_t t_new_e;
		tick_t t_new_m;

		t_use1  = use_time1(d_info.cls);
		t_use2  = use_time2(d_info.cls);
		t_new_e = new_time_e(e_info.cls);
		t_new_m = (m_info.cls == CLS_LOAD) ? 2'd1 : 2'd0;

		stall = (fwable(d_info.reg1, e_info.regw) && t_use1 < t_new_e) ||
			(fwable(d_info.reg1, m_info.regw) && t_use1 < t_new_m) ||
			(fwable(d_info.reg2, e_info.regw) && t_use2 < t_new_e) ||
			(fwable(d_info.reg2, m_info.regw) && t_use2 < t_new_m);

		fwd.d1 = sel_to_d(d_info.reg1, e_info, m_info, w_info);
		fwd.d2 = sel_to_d(d_info.reg2, e_info, m_info, w_info);
		fwd.e1 = sel_to_e(e_info.reg1, m_info, w_info);
		fwd.e2 = sel_to_e(e_info.reg2, m_info, w_info);
		fwd.m  = fwable(m_info.reg2, w_info.regw) ? FWD_W2M_RF : FWD_ORIG;

		// r0 is hardwired, so it never justifies a bypass or a bubble.
		assert ((fwd.d1 == FWD_ORIG || d_info.reg1 != REG_ZERO) &&
			(fwd.d2 == FWD_ORIG || d_info.reg2 != REG_ZERO) &&
			(fwd.e1 == FWD_ORIG || e_info.reg1 != REG_ZERO) &&
			(fwd.e2 == FWD_ORIG || e_info.reg2 != REG_ZERO) &&
			(fwd.m == FWD_ORIG || m_info.reg2 != REG_ZERO) &&
			(!stall || d_info.reg1 != REG_ZERO || d_info.reg2 != REG_ZERO))
			else $error("hazard: zero register drives a select or stall");
	end

	assign pc_enable = ~stall;   // freeze fetch.
	assign d_enable  = ~stall;   // hold decode.

endmodule

`default_nettype wire

// File: rtl/ctrl_word_gen.sv
`default_nettype none

module ctrl_word_gen (
	input  pipe_ctrl_pkg::instr_info_t stage_info [pipe_ctrl_pkg::NUM_STAGES],
	output pipe_ctrl_pkg::ctrl_d_t     ctrl_d,
	output pipe_ctrl_pkg::ctrl_e_t     ctrl_e,
	output pipe_ctrl_pkg::ctrl_m_t     ctrl_m,
	output pipe_ctrl_pkg::ctrl_w_t     ctrl_w
);
	import pipe_ctrl_pkg::*;

	instr_info_t d_info;
	instr_info_t e_info;
	instr_info_t m_info;
	instr_info_t w_info;

	assign d_info = stage_info[ST_D];
	assign e_info = stage_info[ST_E];
	assign m_info = stage_info[ST_M];
	assign w_info = stage_info[ST_W];

	// ########################################
	// decode stage: next pc and immediate
	// ########################################

	always_comb begin
		case (d_info.kind)
			KIND_BEQ:         ctrl_d.npc_mode = NPC_EQUAL;
			KIND_J, KIND_JAL: ctrl_d.npc_mode = NPC_JUMP;
			KIND_JR:          ctrl_d.npc_mode = NPC_REG;
			default:          ctrl_d.npc_mode = NPC_SEQ;
		endcase
		case (d_info.kind)
			KIND_LUI: ctrl_d.ext_mode = EXT_PAD;
			KIND_ORI: ctrl_d.ext_mode = EXT_UNSIGNED;
			default:  ctrl_d.ext_mode = EXT_SIGNED;
		endcase
		ctrl_d.rf_raddr1 = d_info.reg1;
		ctrl_d.rf_raddr2 = d_info.reg2;
	end

	// ########################################
	// execute, memory and write-back
	// ########################################

	always_comb begin
		ctrl_e.alu_src = (e_info.cls == CLS_CAL_I || e_info.cls == CLS_LOAD ||
			e_info.cls == CLS_STORE);
		case (e_info.kind)
			KIND_SUBU:                  ctrl_e.alu_op = ALU_SUB;
			KIND_ADDU, KIND_LW, KIND_SW: ctrl_e.alu_op = ALU_ADD;   // address add for mem.
			default:                    ctrl_e.alu_op = ALU_OR;
		endcase
	end

	assign ctrl_m.dm_we = (m_info.cls == CLS_STORE);

	always_comb begin
		case (w_info.cls)
			CLS_CAL_R, CLS_CAL_I: ctrl_w.wb_src = WB_ALU;
			CLS_LOAD:             ctrl_w.wb_src = WB_MEM;
			default:              ctrl_w.wb_src = (w_info.kind == KIND_JAL) ? WB_PC8 : WB_NONE;
		endcase
		ctrl_w.rf_we = (w_info.cls == CLS_CAL_R || w_info.cls == CLS_CAL_I ||
			w_info.cls == CLS_LOAD || w_info.kind == KIND_JAL);
		ctrl_w.rf_waddr = w_info.regw;

		// a register write always has a data source.
		assert (!ctrl_w.rf_we || ctrl_w.wb_src != WB_NONE)
			else $error("ctrl: rf_we without write-back source, kind %0d", w_info.kind);
	end

endmodule

`default_nettype wire

// File: rtl/pipe_ctrl_top.sv
`default_nettype none

module pipe_ctrl_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  pipe_ctrl_pkg::instr_t  d_instr,
	output logic                   pc_enable,
	output logic                   d_enable,
	output logic                   e_flush,
	output pipe_ctrl_pkg::fwd_t    fwd,
	output pipe_ctrl_pkg::ctrl_d_t ctrl_d,
	output pipe_ctrl_pkg::ctrl_e_t ctrl_e,
	output pipe_ctrl_pkg::ctrl_m_t ctrl_m,
	output pipe_ctrl_pkg::ctrl_w_t ctrl_w
);
	import pipe_ctrl_pkg::*;

	instr_t      stage_instr [NUM_STAGES];
	instr_info_t stage_info  [NUM_STAGES];

	// e_flush is the stall itself, so it also steers the tracker.
	stage_tracker u_tracker (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (e_flush),
		.d_instr     (d_instr),
		.stage_instr (stage_instr)
	);

	// ########################################
	// one decoder per stage
	// ########################################

	for (genvar i = 0; i < NUM_STAGES; i++) begin : g_dec
		instr_decoder u_dec (
			.instr (stage_instr[i]),
			.info  (stage_info[i])
		);
	end

	hazard_unit u_hazard (
		.stage_info (stage_info),
		.stall      (e_flush),
		.pc_enable  (pc_enable),
		.d_enable   (d_enable),
		.fwd        (fwd)
	);

	ctrl_word_gen u_ctrl (
		.stage_info (stage_info),
		.ctrl_d     (ctrl_d),
		.ctrl_e     (ctrl_e),
		.ctrl_m     (ctrl_m),
		.ctrl_w     (ctrl_w)
	);

endmodule

`default_nettype wire

// File: tb/tb_pipe_ctrl.sv
`default_nettype none

module tb_pipe_ctrl;
	import pipe_ctrl_pkg::*;

	localparam int RESET_CYCLES   = 8;
	localparam int NUM_RANDOM     = 300;
	localparam int DIRECTED_WORDS = 80;   // upper bound on directed issues.
	// each issue holds decode for at most 3 cycles (2 stall + 1).
	localparam int STIM_CYCLES    = 2 * RESET_CYCLES + 3 * (DIRECTED_WORDS + NUM_RANDOM);
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

	logic        clk;
	logic        rst_n;
	instr_t      d_instr;
	logic        pc_enable;
	logic        d_enable;
	logic        e_flush;
	fwd_t        fwd;
	ctrl_d_t     ctrl_d;
	ctrl_e_t     ctrl_e;
	ctrl_m_t     ctrl_m;
	ctrl_w_t     ctrl_w;

	instr_t      sh_e;
	instr_t      sh_m;
	instr_t      sh_w;
	instr_info_t di;
	instr_info_t ei;
	instr_info_t mi;
	instr_info_t wi;
	logic        exp_stall;
	fwd_t        exp_fwd;
	ctrl_d_t     exp_ctrl_d;
	ctrl_e_t     exp_ctrl_e;
	ctrl_m_t     exp_ctrl_m;
	ctrl_w_t     exp_ctrl_w;

	int          errors;
	int          err_mark;
	int          tests;
	int          cycles;
	logic [31:0] rng;

	pipe_ctrl_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.d_instr   (d_instr),
		.pc_enable (pc_enable),
		.d_enable  (d_enable),
		.e_flush   (e_flush),
		.fwd       (fwd),
		.ctrl_d    (ctrl_d),
		.ctrl_e    (ctrl_e),
		.ctrl_m    (ctrl_m),
		.ctrl_w    (ctrl_w)
	);

	always #2 clk = ~clk;

	// ########################################
	// reference model of the decode rules
	// ########################################

	function automatic instr_info_t model_decode(input instr_t w);
		reg_idx_t    rs;
		reg_idx_t    rt;
		reg_idx_t    rd;
		instr_info_t r;
		rs = w[25:21];
		rt = w[20:16];
		rd = w[15:11];
		r  = '{KIND_UNKNOWN, CLS_NONE, 5'd0, 5'd0, 5'd0};
		if (w == 32'h0) begin
			r.kind = KIND_NOP;
		end else begin
			case (w[31:26])
				6'h00: begin
					if (w[10:6] == 5'd0 && w[5:0] == 6'h21)
						r = '{KIND_ADDU, CLS_CAL_R, rs, rt, rd};
					else if (w[10:6] == 5'd0 && w[5:0] == 6'h23)
						r = '{KIND_SUBU, CLS_CAL_R, rs, rt, rd};
					else if ({rt, rd} == 10'd0 && w[5:0] == 6'h08)
						r = '{KIND_JR, CLS_JUMP_R, rs, 5'd0, 5'd0};
				end
				6'h02: r = '{KIND_J, CLS_JUMP_I, 5'd0, 5'd0, 5'd0};
				6'h03: r = '{KIND_JAL, CLS_JUMP_I, 5'd0, 5'd0, 5'd31};   // link reg.
				6'h04: r = '{KIND_BEQ, CLS_BRANCH, rs, rt, 5'd0};
				6'h0D: r = '{KIND_ORI, CLS_CAL_I, rs, 5'd0, rt};
				6'h0F: begin
					if (rs == 5'd0)
						r = '{KIND_LUI, CLS_CAL_I, 5'd0, 5'd0, rt};
				end
				6'h23: r = '{KIND_LW, CLS_LOAD, rs, 5'd0, rt};
				6'h2B: r = '{KIND_SW, CLS_STORE, rs, rt, 5'd0};
				default: ;
			endcase
		end
		return r;
	endfunction

	function automatic logic reg_match(input reg_idx_t src, input reg_idx_t dst);
		return src != 5'd0 && src == dst;
	endfunction

	// 3 means the operand is never read.
	function automatic int use_time_rs(input instr_class_e c);
		if (c == CLS_CAL_R || c == CLS_CAL_I || c == CLS_LOAD || c == CLS_STORE)
			return 1;
		if (c == CLS_BRANCH || c == CLS_JUMP_R)
			return 0;
		return 3;
	endfunction

	function automatic int use_time_rt(input instr_class_e c);
		if (c == CLS_STORE)
			return 2;
		if (c == CLS_CAL_R)
			return 1;
		if (c == CLS_BRANCH)
			return 0;
		return 3;
	endfunction

	function automatic int ready_time_e(input instr_class_e c);
		if (c == CLS_LOAD)
			return 2;
		return (c == CLS_CAL_R || c == CLS_CAL_I) ? 1 : 0;
	endfunction

	function automatic fwd_sel_e fwd_to_decode(input reg_idx_t r, input instr_info_t e,
		input instr_info_t m, input instr_info_t w);
		if (reg_match(r, e.regw) && e.kind == KIND_JAL)
			return FWD_E2D_PC8;
		if (reg_match(r, m.regw)) begin
			if (m.kind == KIND_JAL)
				return FWD_M2D_PC8;
			if (m.cls == CLS_CAL_R || m.cls == CLS_CAL_I)
				return FWD_M2D_ALU;
		end
		return reg_match(r, w.regw) ? FWD_W2D_RF : FWD_ORIG;
	endfunction

	function automatic fwd_sel_e fwd_to_execute(input reg_idx_t r, input instr_info_t m,
		input instr_info_t w);
		if (reg_match(r, m.regw)) begin
			if (m.kind == KIND_JAL)
				return FWD_M2E_PC8;
			if (m.cls == CLS_CAL_R || m.cls == CLS_CAL_I)
				return FWD_M2E_ALU;
		end
		return reg_match(r, w.regw) ? FWD_W2E_RF : FWD_ORIG;
	endfunction

	// ########################################
	// shadow pipeline and expected outputs
	// ########################################

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh_e <= 32'h0;
			sh_m <= 32'h0;
			sh_w <= 32'h0;
		end else begin
			sh_e <= exp_stall ? 32'h0 : d_instr;   // bubble on stall.
			sh_m <= sh_e;
			sh_w <= sh_m;
		end
	end

	always_comb begin
		di = model_decode(d_instr);
		ei = model_decode(sh_e);
		mi = model_decode(sh_m);
		wi = model_decode(sh_w);

		exp_stall = (reg_match(di.reg1, ei.regw) && use_time_rs(di.cls) < ready_time_e(ei.cls))
			|| (reg_match(di.reg2, ei.regw) && use_time_rt(di.cls) < ready_time_e(ei.cls))
			|| (reg_match(di.reg1, mi.regw) && mi.cls == CLS_LOAD && use_time_rs(di.cls) < 1)
			|| (reg_match(di.reg2, mi.regw) && mi.cls == CLS_LOAD && use_time_rt(di.cls) < 1);

		exp_fwd.d1 = fwd_to_decode(di.reg1, ei, mi, wi);
		exp_fwd.d2 = fwd_to_decode(di.reg2, ei, mi, wi);
		exp_fwd.e1 = fwd_to_execute(ei.reg1, mi, wi);
		exp_fwd.e2 = fwd_to_execute(ei.reg2, mi, wi);
		exp_fwd.m  = reg_match(mi.reg2, wi.regw) ? FWD_W2M_RF : FWD_ORIG;

		exp_ctrl_d.npc_mode = (di.kind == KIND_BEQ) ? NPC_EQUAL :
			(di.kind == KIND_J || di.kind == KIND_JAL) ? NPC_JUMP :
			(di.kind == KIND_JR) ? NPC_REG : NPC_SEQ;
		exp_ctrl_d.ext_mode = (di.kind == KIND_LUI) ? EXT_PAD :
			(di.kind == KIND_ORI) ? EXT_UNSIGNED : EXT_SIGNED;
		exp_ctrl_d.rf_raddr1 = di.reg1;
		exp_ctrl_d.rf_raddr2 = di.reg2;

		exp_ctrl_e.alu_src = (ei.cls == CLS_CAL_I || ei.cls == CLS_LOAD || ei.cls == CLS_STORE);
		if (ei.kind == KIND_SUBU)
			exp_ctrl_e.alu_op = ALU_SUB;
		else if (ei.kind == KIND_ADDU || ei.kind == KIND_LW || ei.kind == KIND_SW)
			exp_ctrl_e.alu_op = ALU_ADD;
		else
			exp_ctrl_e.alu_op = ALU_OR;

		exp_ctrl_m.dm_we = (mi.cls == CLS_STORE);

		if (wi.cls == CLS_CAL_R || wi.cls == CLS_CAL_I)
			exp_ctrl_w.wb_src = WB_ALU;
		else if (wi.cls == CLS_LOAD)
			exp_ctrl_w.wb_src = WB_MEM;
		else if (wi.kind == KIND_JAL)
			exp_ctrl_w.wb_src = WB_PC8;
		else
			exp_ctrl_w.wb_src = WB_NONE;
		exp_ctrl_w.rf_we    = (wi.cls == CLS_CAL_R || wi.cls == CLS_CAL_I ||
			wi.cls == CLS_LOAD || wi.kind == KIND_JAL);
		exp_ctrl_w.rf_waddr = wi.regw;
	end

	// ########################################
	// checks
	// ########################################

	task automatic flag_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("** Error: %s at cycle %0d: got %h, expected %h", name, cycles, got, want);
	endtask

	a_stall: assert property (@(posedge clk) disable iff (!rst_n) e_flush == exp_stall)
		else flag_mismatch("e_flush", 32'($sampled(e_flush)), 32'($sampled(exp_stall)));
	a_pc_en: assert property (@(posedge clk) disable iff (!rst_n) pc_enable == !exp_stall)
		else flag_mismatch("pc_enable", 32'($sampled(pc_enable)), 32'(!$sampled(exp_stall)));
	a_d_en: assert property (@(posedge clk) disable iff (!rst_n) d_enable == !exp_stall)
		else flag_mismatch("d_enable", 32'($sampled(d_enable)), 32'(!$sampled(exp_stall)));
	a_fwd: assert property (@(posedge clk) disable iff (!rst_n) fwd == exp_fwd)
		else flag_mismatch("fwd", 32'($sampled(fwd)), 32'($sampled(exp_fwd)));
	a_ctrl_d: assert property (@(posedge clk) disable iff (!rst_n) ctrl_d == exp_ctrl_d)
		else flag_mismatch("ctrl_d", 32'($sampled(ctrl_d)), 32'($sampled(exp_ctrl_d)));
	a_ctrl_e: assert property (@(posedge clk) disable iff (!rst_n) ctrl_e == exp_ctrl_e)
		else flag_mismatch("ctrl_e", 32'($sampled(ctrl_e)), 32'($sampled(exp_ctrl_e)));
	a_ctrl_m: assert property (@(posedge clk) disable iff (!rst_n) ctrl_m == exp_ctrl_m)
		else flag_mismatch("ctrl_m", 32'($sampled(ctrl_m)), 32'($sampled(exp_ctrl_m)));
	a_ctrl_w: assert property (@(posedge clk) disable iff (!rst_n) ctrl_w == exp_ctrl_w)
		else flag_mismatch("ctrl_w", 32'($sampled(ctrl_w)), 32'($sampled(exp_ctrl_w)));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: stimulus still running after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ########################################
	// stimulus helpers
	// ########################################

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic instr_t r_word(input logic [5:0] funct, input reg_idx_t rs,
		input reg_idx_t rt, input reg_idx_t rd);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic instr_t i_word(input logic [5:0] op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// registers 0..7 only, so hazards come often.
	function automatic instr_t random_word(input logic [31:0] r);
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		rs = {2'b00, r[8:6]};
		rt = {2'b00, r[11:9]};
		rd = {2'b00, r[14:12]};
		case (r[3:0])
			4'd0:    return 32'h0;
			4'd2:    return r_word(6'h23, rs, rt, rd);
			4'd3:    return i_word(6'h0D, rs, rt, r[31:16]);
			4'd4:    return i_word(6'h0F, 5'd0, rt, r[31:16]);
			4'd5:    return i_word(6'h23, rs, rt, r[31:16]);
			4'd6:    return i_word(6'h2B, rs, rt, r[31:16]);
			4'd7:    return i_word(6'h04, rs, rt, r[31:16]);
			4'd8:    return {6'h02, r[31:6]};
			4'd9:    return {6'h03, r[31:6]};
			4'd10:   return r_word(6'h08, rs, 5'd0, 5'd0);
			4'd11:   return {6'h3F, r[31:6]};   // unknown opcode.
			default: return r_word(6'h21, rs, rt, rd);
		endcase
	endfunction

	// called on a rising edge; returns on the edge where the word leaves decode.
	task automatic issue(input instr_t w);
		d_instr <= w;
		@(negedge clk);
		while (e_flush)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic drain();
		repeat (4)
			issue(32'h0);
	endtask

	task automatic pulse_reset();
		rst_n   <= 1'b0;
		d_instr <= 32'h0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic close_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	// ########################################
	// test sequence
	// ########################################

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		d_instr  = 32'h0;
		errors   = 0;
		err_mark = 0;
		tests    = 0;
		cycles   = 0;
		rng      = 32'd11497;
		repeat (RESET_CYCLES)
			@(posedge clk);
		rst_n <= 1'b1;

		issue(r_word(6'h21, 5'd1, 5'd2, 5'd3));       // addu.
		issue(r_word(6'h23, 5'd4, 5'd5, 5'd6));       // subu.
		issue(i_word(6'h0D, 5'd8, 5'd7, 16'h1234));   // ori.
		issue(i_word(6'h0F, 5'd0, 5'd9, 16'hABCD));   // lui.
		issue(i_word(6'h23, 5'd11, 5'd10, 16'h0004));
		issue(i_word(6'h2B, 5'd13, 5'd12, 16'h0008));
		issue(i_word(6'h04, 5'd14, 5'd15, 16'hFFFE));
		issue({6'h02, 26'h0000100});
		issue({6'h03, 26'h0000200});
		issue(r_word(6'h08, 5'd16, 5'd0, 5'd0));      // jr.
		issue({6'h00, 5'd1, 5'd2, 5'd3, 5'd1, 6'h21});  // addu with shamt set.
		issue(i_word(6'h0F, 5'd4, 5'd5, 16'h0001));   // lui with rs set.
		issue(r_word(6'h08, 5'd6, 5'd7, 5'd0));       // jr with rt set.
		issue({6'h3F, 26'h155AA55});
		drain();
		close_test("decode kinds");

		issue(i_word(6'h2B, 5'd2, 5'd1, 16'h0000));
		issue(r_word(6'h21, 5'd4, 5'd5, 5'd3));
		issue(i_word(6'h23, 5'd7, 5'd6, 16'h0010));
		issue({6'h03, 26'h0000040});
		issue(i_word(6'h0D, 5'd9, 5'd8, 16'h0001));
		drain();
		close_test("stage latency");

		issue(i_word(6'h23, 5'd1, 5'd5, 16'h0000));
		issue(r_word(6'h21, 5'd5, 5'd2, 5'd6));       // one stall.
		drain();
		issue(i_word(6'h23, 5'd1, 5'd5, 16'h0000));
		issue(i_word(6'h2B, 5'd5, 5'd7, 16'h0000));   // base, one stall.
		drain();
		issue(i_word(6'h23, 5'd1, 5'd5, 16'h0000));
		issue(i_word(6'h04, 5'd5, 5'd0, 16'h0003));   // branch, two stalls.
		drain();
		issue(i_word(6'h23, 5'd1, 5'd5, 16'h0000));
		issue(i_word(6'h2B, 5'd7, 5'd5, 16'h0000));   // store data, no stall.
		drain();
		close_test("load use stall");

		issue(i_word(6'h0D, 5'd0, 5'd1, 16'h0005));
		issue(r_word(6'h21, 5'd1, 5'd1, 5'd2));
		issue(r_word(6'h21, 5'd2, 5'd1, 5'd3));
		issue({6'h03, 26'h0000080});
		issue(r_word(6'h21, 5'd31, 5'd31, 5'd4));
		issue(32'h0);
		issue(r_word(6'h21, 5'd31, 5'd0, 5'd5));
		issue(r_word(6'h08, 5'd31, 5'd0, 5'd0));
		issue(i_word(6'h0D, 5'd0, 5'd0, 16'h0001));   // write to r0.
		issue(r_word(6'h21, 5'd0, 5'd0, 5'd7));
		issue(i_word(6'h2B, 5'd0, 5'd3, 16'h0000));
		issue(i_word(6'h2B, 5'd0, 5'd7, 16'h0004));
		drain();
		close_test("forwarding");

		// reset lands with lw, sw and jal still in the stages.
		issue(i_word(6'h23, 5'd1, 5'd2, 16'h0000));
		issue(i_word(6'h2B, 5'd3, 5'd2, 16'h0000));
		issue({6'h03, 26'h0000010});
		pulse_reset();
		drain();
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rng = xorshift32(rng);
			issue(random_word(rng));
		end
		drain();
		close_test("random sequence");

		$display("summary: %0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/pipe_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/stage_tracker.sv
rtl/hazard_unit.sv
rtl/ctrl_word_gen.sv
rtl/pipe_ctrl_top.sv
tb/tb_pipe_ctrl.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline control testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_pipe_ctrl \
	-f compile.f

./obj_dir/Vtb_pipe_ctrl > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0
